//--- common/lsu_cfg_pkg.sv
/*
 * Configuration constants for the load/store unit.
 * Data and address widths, buffer and pipeline depths, and the
 * exception cause codes reported for misaligned accesses.
 */
package lsu_cfg_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned IMM_W      = 12;
  localparam int unsigned TRANS_ID_W = 3;
  localparam int unsigned BE_W       = XLEN / 8;

  // Request buffer geometry
  localparam int unsigned REQ_DEPTH = 2;
  localparam int unsigned REQ_PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int unsigned REQ_CNT_W = $clog2(REQ_DEPTH + 1);

  // Return path register stages
  localparam int unsigned LOAD_PIPE_REGS  = 1;
  localparam int unsigned STORE_PIPE_REGS = 1;

  // RISC-V mcause encodings
  localparam logic [XLEN-1:0] CAUSE_LD_MISALIGNED = XLEN'(4);
  localparam logic [XLEN-1:0] CAUSE_ST_MISALIGNED = XLEN'(6);

endpackage

//--- common/lsu_types_pkg.sv
/*
 * Data types of the load/store unit.
 * Operation encoding, the issued instruction, the buffered request,
 * the memory port request and response, and the returned result.
 */
package lsu_types_pkg;

  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // Instruction as handed over by the issue stage
  typedef struct packed {
    lsu_op_e                                 op;
    logic [lsu_cfg_pkg::XLEN-1:0]            operand_a;
    logic [lsu_cfg_pkg::IMM_W-1:0]           imm;
    logic [lsu_cfg_pkg::XLEN-1:0]            operand_b;
    logic [lsu_cfg_pkg::TRANS_ID_W-1:0]      trans_id;
  } fu_data_t;

  typedef struct packed {
    logic                                    valid;
    logic [lsu_cfg_pkg::XLEN-1:0]            cause;
    logic [lsu_cfg_pkg::ADDR_W-1:0]          tval;
  } exception_t;

  // Request after address generation, as held in the buffer
  typedef struct packed {
    logic                                    is_store;
    lsu_op_e                                 op;
    logic [lsu_cfg_pkg::ADDR_W-1:0]          vaddr;
    logic [lsu_cfg_pkg::XLEN-1:0]            wdata;
    logic [lsu_cfg_pkg::BE_W-1:0]            be;
    logic [lsu_cfg_pkg::TRANS_ID_W-1:0]      trans_id;
    exception_t                              ex;
  } lsu_ctrl_t;

  typedef struct packed {
    logic                                    req;
    logic                                    we;
    logic [lsu_cfg_pkg::ADDR_W-1:0]          addr;
    logic [lsu_cfg_pkg::BE_W-1:0]            be;
    logic [lsu_cfg_pkg::XLEN-1:0]            wdata;
  } mem_req_t;

  typedef struct packed {
    logic                                    gnt;
    logic                                    rvalid;
    logic [lsu_cfg_pkg::XLEN-1:0]            rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                                    valid;
    logic [lsu_cfg_pkg::TRANS_ID_W-1:0]      trans_id;
    logic [lsu_cfg_pkg::XLEN-1:0]            result;
    exception_t                              ex;
  } lsu_result_t;

endpackage

//--- hdl/lsu_agu.sv
`timescale 1ns/1ps
/*
 * Address generation for the load/store unit, purely combinational.
 * Forms the effective address, byte enables and lane-shifted store
 * data, and flags misaligned half and word accesses as exceptions.
 */
module lsu_agu (
  input  lsu_types_pkg::fu_data_t  fu_data_i,
  input  logic                     valid_i,
  output lsu_types_pkg::lsu_ctrl_t ctrl_o
);
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;

  logic [ADDR_W-1:0] vaddr;
  logic [1:0]        offset;
  logic              is_store;
  logic              misaligned;

  // Effective address is operand plus sign-extended immediate
  assign vaddr  = fu_data_i.operand_a
                + {{(XLEN - IMM_W){fu_data_i.imm[IMM_W-1]}}, fu_data_i.imm};
  assign offset = vaddr[1:0];

  assign is_store = fu_data_i.op inside {SB, SH, SW};

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.is_store = is_store;
    ctrl_o.op       = fu_data_i.op;
    ctrl_o.vaddr    = vaddr;
    ctrl_o.trans_id = fu_data_i.trans_id;
    // Store data moves up to the lanes it will occupy in the word
    ctrl_o.wdata    = fu_data_i.operand_b << {offset, 3'b000};

    misaligned = 1'b0;
    case (fu_data_i.op)
      LB, LBU, SB: begin
        ctrl_o.be = {{(BE_W - 1){1'b0}}, 1'b1} << offset;
      end
      LH, LHU, SH: begin
        ctrl_o.be  = {{(BE_W - 2){1'b0}}, 2'b11} << offset;
        misaligned = offset[0];
      end
      default: begin
        ctrl_o.be  = '1;
        misaligned = |offset;
      end
    endcase

    if (valid_i && misaligned) begin
      ctrl_o.ex.valid = 1'b1;
      ctrl_o.ex.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
      ctrl_o.ex.tval  = vaddr;
    end
  end

endmodule

//--- hdl/lsu_req_buffer.sv
`timescale 1ns/1ps
/*
 * Request FIFO between issue and the load and store units.
 * Accepts a request whenever an entry is free and shows the oldest
 * entry at the head until one of the units pops it.
 */
module lsu_req_buffer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  lsu_types_pkg::lsu_ctrl_t ctrl_i,
  output logic                     ready_o,
  output lsu_types_pkg::lsu_ctrl_t head_o,
  output logic                     head_valid_o,
  input  logic                     pop_i
);
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;

  lsu_ctrl_t            entry_q [REQ_DEPTH];
  logic [REQ_PTR_W-1:0] wr_ptr_q;
  logic [REQ_PTR_W-1:0] rd_ptr_q;
  logic [REQ_CNT_W-1:0] count_q;
  logic                 do_push;
  logic                 do_pop;

  function automatic logic [REQ_PTR_W-1:0] next_ptr(input logic [REQ_PTR_W-1:0] ptr);
    if (ptr == REQ_PTR_W'(REQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + REQ_PTR_W'(1);
  endfunction

  assign ready_o      = count_q < REQ_CNT_W'(REQ_DEPTH);
  assign head_valid_o = count_q != '0;
  assign head_o       = entry_q[rd_ptr_q];
  assign do_push      = push_i && ready_o;
  assign do_pop       = pop_i && head_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + REQ_CNT_W'(1);
        2'b01:   count_q <= count_q - REQ_CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      entry_q[wr_ptr_q] <= ctrl_i;
    end
  end

endmodule

//--- load_unit/load_unit.sv
`timescale 1ns/1ps
/*
 * Load unit. Takes a load from the request buffer head, reads the
 * word from memory, extracts and extends the addressed lanes, and
 * reports the result. Misaligned loads skip memory entirely.
 */
module load_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  lsu_types_pkg::lsu_ctrl_t   head_i,
  input  logic                       head_valid_i,
  output logic                       pop_o,
  output lsu_types_pkg::mem_req_t    mem_req_o,
  input  lsu_types_pkg::mem_rsp_t    mem_rsp_i,
  output lsu_types_pkg::lsu_result_t result_o
);
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_REQUEST,
    LD_WAIT_DATA,
    LD_DONE
  } ld_state_e;

  ld_state_e       state_q;
  ld_state_e       state_d;
  logic            is_load;
  logic [XLEN-1:0] rdata_q;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] ext_data;

  assign is_load = head_valid_i && !head_i.is_store;

  // ------------------------------------------------------------------
  // Control FSM and memory request
  // ------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    mem_req_o = '0;
    case (state_q)
      LD_IDLE: begin
        if (is_load) begin
          if (head_i.ex.valid) begin
            state_d = LD_DONE;
          end else begin
            mem_req_o.req = 1'b1;
            state_d = mem_rsp_i.gnt ? LD_WAIT_DATA : LD_REQUEST;
          end
        end
      end
      LD_REQUEST: begin
        mem_req_o.req = 1'b1;
        if (mem_rsp_i.gnt) begin
          state_d = LD_WAIT_DATA;
        end
      end
      LD_WAIT_DATA: begin
        if (mem_rsp_i.rvalid) begin
          state_d = LD_DONE;
        end
      end
      default: begin
        state_d = LD_IDLE;
      end
    endcase
    // Head stays put until the pop, so the request is stable
    if (mem_req_o.req) begin
      mem_req_o.addr = {head_i.vaddr[ADDR_W-1:2], 2'b00};
      mem_req_o.be   = head_i.be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LD_WAIT_DATA && mem_rsp_i.rvalid) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

  // ------------------------------------------------------------------
  // Lane select and extension
  // ------------------------------------------------------------------
  always_comb begin
    lane_data = rdata_q >> {head_i.vaddr[1:0], 3'b000};
    case (head_i.op)
      LB:      ext_data = {{(XLEN - 8){lane_data[7]}}, lane_data[7:0]};
      LBU:     ext_data = {{(XLEN - 8){1'b0}}, lane_data[7:0]};
      LH:      ext_data = {{(XLEN - 16){lane_data[15]}}, lane_data[15:0]};
      LHU:     ext_data = {{(XLEN - 16){1'b0}}, lane_data[15:0]};
      default: ext_data = lane_data;
    endcase
  end

  always_comb begin
    result_o = '0;
    if (state_q == LD_DONE) begin
      result_o.valid    = 1'b1;
      result_o.trans_id = head_i.trans_id;
      result_o.ex       = head_i.ex;
      result_o.result   = head_i.ex.valid ? '0 : ext_data;
    end
  end

  assign pop_o = (state_q == LD_DONE);

endmodule

//--- store_unit/store_unit.sv
`timescale 1ns/1ps
/*
 * Store unit. Takes a store from the request buffer head and holds a
 * write request with lane-aligned data and byte enables until it is
 * granted. Misaligned stores are reported without touching memory.
 */
module store_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  lsu_types_pkg::lsu_ctrl_t   head_i,
  input  logic                       head_valid_i,
  output logic                       pop_o,
  output lsu_types_pkg::mem_req_t    mem_req_o,
  input  lsu_types_pkg::mem_rsp_t    mem_rsp_i,
  output lsu_types_pkg::lsu_result_t result_o
);
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_DONE
  } st_state_e;

  st_state_e state_q;
  st_state_e state_d;
  logic      is_store;

  assign is_store = head_valid_i && head_i.is_store;

  always_comb begin
    state_d   = state_q;
    mem_req_o = '0;
    case (state_q)
      ST_IDLE: begin
        if (is_store) begin
          if (head_i.ex.valid) begin
            state_d = ST_DONE;
          end else begin
            mem_req_o.req = 1'b1;
            state_d = mem_rsp_i.gnt ? ST_DONE : ST_REQUEST;
          end
        end
      end
      ST_REQUEST: begin
        mem_req_o.req = 1'b1;
        if (mem_rsp_i.gnt) begin
          state_d = ST_DONE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
    if (mem_req_o.req) begin
      mem_req_o.we    = 1'b1;
      mem_req_o.addr  = {head_i.vaddr[ADDR_W-1:2], 2'b00};
      mem_req_o.be    = head_i.be;
      mem_req_o.wdata = head_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Write has completed at grant and the result carries no data
  always_comb begin
    result_o = '0;
    if (state_q == ST_DONE) begin
      result_o.valid    = 1'b1;
      result_o.trans_id = head_i.trans_id;
      result_o.ex       = head_i.ex;
    end
  end

  assign pop_o = (state_q == ST_DONE);

endmodule

//--- hdl/lsu_result_pipe.sv
`timescale 1ns/1ps
/*
 * Pipeline register for a returned result of any payload type.
 * Delays the input by DEPTH cycles; DEPTH of 0 passes straight through.
 */
module lsu_result_pipe #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t d_i,
  output payload_t d_o
);

  if (DEPTH == 0) begin : gen_bypass
    assign d_o = d_i;
  end else begin : gen_stages
    payload_t stage_q [DEPTH];

    // Shift register, stage 0 takes the input
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

//--- hdl/load_store_unit.sv
`timescale 1ns/1ps
/*
 * Load/store unit top level without address translation.
 * Address generation feeds a two-entry request buffer; the load and
 * store units serve its head in order on their own memory ports, and
 * each result leaves through a return pipeline register.
 */
module load_store_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  lsu_types_pkg::fu_data_t    fu_data_i,
  input  logic                       lsu_valid_i,
  output logic                       lsu_ready_o,
  output lsu_types_pkg::mem_req_t    ld_mem_req_o,
  output lsu_types_pkg::mem_req_t    st_mem_req_o,
  input  lsu_types_pkg::mem_rsp_t    ld_mem_rsp_i,
  input  lsu_types_pkg::mem_rsp_t    st_mem_rsp_i,
  output lsu_types_pkg::lsu_result_t load_result_o,
  output lsu_types_pkg::lsu_result_t store_result_o
);
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;

  lsu_ctrl_t   agu_ctrl;
  lsu_ctrl_t   head;
  logic        head_valid;
  logic        ld_pop;
  logic        st_pop;
  logic        buf_pop;
  lsu_result_t ld_result;
  lsu_result_t st_result;

  // ------------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------------
  lsu_agu u_agu (
    .fu_data_i (fu_data_i),
    .valid_i   (lsu_valid_i),
    .ctrl_o    (agu_ctrl)
  );

  // Only one unit ever owns the head, so the pops never collide
  assign buf_pop = ld_pop | st_pop;

  lsu_req_buffer u_req_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (lsu_valid_i),
    .ctrl_i       (agu_ctrl),
    .ready_o      (lsu_ready_o),
    .head_o       (head),
    .head_valid_o (head_valid),
    .pop_i        (buf_pop)
  );

  // ------------------------------------------------------------------
  // Load and store units
  // ------------------------------------------------------------------
  load_unit u_load_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .head_valid_i (head_valid),
    .pop_o        (ld_pop),
    .mem_req_o    (ld_mem_req_o),
    .mem_rsp_i    (ld_mem_rsp_i),
    .result_o     (ld_result)
  );

  store_unit u_store_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .head_valid_i (head_valid),
    .pop_o        (st_pop),
    .mem_req_o    (st_mem_req_o),
    .mem_rsp_i    (st_mem_rsp_i),
    .result_o     (st_result)
  );

  // ------------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------------
  lsu_result_pipe #(
    .payload_t (lsu_result_t),
    .DEPTH     (LOAD_PIPE_REGS)
  ) u_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_result_o)
  );

  lsu_result_pipe #(
    .payload_t (lsu_result_t),
    .DEPTH     (STORE_PIPE_REGS)
  ) u_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_result_o)
  );

endmodule

//--- verif/lsu_props.sv
`timescale 1ns/1ps
/*
 * Concurrent assertions for the load/store unit, bound into the top
 * level. Covers memory request stability, issue flow control, the
 * result encoding of exceptions and the request state during reset.
 */
module lsu_props (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       lsu_valid_i,
  input logic                       lsu_ready_o,
  input lsu_types_pkg::mem_req_t    ld_mem_req_o,
  input lsu_types_pkg::mem_req_t    st_mem_req_o,
  input lsu_types_pkg::mem_rsp_t    ld_mem_rsp_i,
  input lsu_types_pkg::mem_rsp_t    st_mem_rsp_i,
  input lsu_types_pkg::lsu_result_t load_result_o
);

  // A request that is not granted must come back unchanged
  a_ld_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_mem_req_o.req && !ld_mem_rsp_i.gnt |=> ld_mem_req_o.req && $stable(ld_mem_req_o))
    else $error("load memory request dropped or changed before grant");

  a_st_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_mem_req_o.req && !st_mem_rsp_i.gnt |=> st_mem_req_o.req && $stable(st_mem_req_o))
    else $error("store memory request dropped or changed before grant");

  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !lsu_ready_o |-> !lsu_valid_i)
    else $error("request issued while the request buffer was full");

  // Exceptions carry no data
  a_ld_ex_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_result_o.valid && load_result_o.ex.valid |-> load_result_o.result == '0)
    else $error("load exception result carries nonzero data");

  a_req_low_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !ld_mem_req_o.req && !st_mem_req_o.req)
    else $error("memory request raised during reset");

endmodule

bind load_store_unit lsu_props u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .lsu_valid_i    (lsu_valid_i),
  .lsu_ready_o    (lsu_ready_o),
  .ld_mem_req_o   (ld_mem_req_o),
  .st_mem_req_o   (st_mem_req_o),
  .ld_mem_rsp_i   (ld_mem_rsp_i),
  .st_mem_rsp_i   (st_mem_rsp_i),
  .load_result_o  (load_result_o)
);

//--- verif/tb_load_store_unit.sv
`timescale 1ns/1ps
/*
 * Testbench for the load/store unit. Runs directed tests against a
 * word-addressed memory model with random grant stalls and checks
 * every result, in issue order, against a reference memory.
 */
module tb_load_store_unit;
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 2000;
  localparam int MEM_WORDS   = 256;
  localparam int WAIT_CYCLES = 400;

  // Result together with the port it belongs to and its memory word
  typedef struct packed {
    logic        is_store;
    logic [7:0]  word_idx;
    lsu_result_t res;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst_n;
  fu_data_t    fu_data;
  logic        lsu_valid;
  logic        lsu_ready;
  mem_req_t    ld_mem_req;
  mem_req_t    st_mem_req;
  mem_rsp_t    ld_mem_rsp;
  mem_rsp_t    st_mem_rsp;
  lsu_result_t load_result;
  lsu_result_t store_result;

  logic            ld_grant_ok = 1'b0;
  logic            st_grant_ok = 1'b0;
  logic            ld_rvalid   = 1'b0;
  logic [XLEN-1:0] ld_rdata    = '0;
  logic [XLEN-1:0] mem     [MEM_WORDS];
  logic [XLEN-1:0] ref_mem [MEM_WORDS];

  int      seed       = 32'h3984c70a;
  int      req_cycles = 0;
  int      errors;
  int      checks;
  int      tests_run;
  int      tests_failed;
  expect_t exp_q [$];
  expect_t obs_q [$];

  load_store_unit u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .fu_data_i      (fu_data),
    .lsu_valid_i    (lsu_valid),
    .lsu_ready_o    (lsu_ready),
    .ld_mem_req_o   (ld_mem_req),
    .st_mem_req_o   (st_mem_req),
    .ld_mem_rsp_i   (ld_mem_rsp),
    .st_mem_rsp_i   (st_mem_rsp),
    .load_result_o  (load_result),
    .store_result_o (store_result)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------
  // Reference rules for addresses, lanes and extension
  // ------------------------------------------------------------------
  function automatic int word_index(logic [ADDR_W-1:0] addr);
    return int'(addr[9:2]);
  endfunction

  function automatic logic [XLEN-1:0] fill_word(int unsigned addr);
    logic [31:0] a;
    a = addr;
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic int size_of(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_misaligned(lsu_op_e op, logic [ADDR_W-1:0] addr);
    return (size_of(op) == 2 && addr[0]) || (size_of(op) == 4 && addr[1:0] != 2'b00);
  endfunction

  function automatic logic [XLEN-1:0] load_value(lsu_op_e op, logic [XLEN-1:0] word,
                                                 int off);
    logic [XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < size_of(op); i++) begin
      v[8*i +: 8] = word[8*(off+i) +: 8];
    end
    if (op == LB && v[7]) begin
      v[XLEN-1:8] = '1;
    end
    if (op == LH && v[15]) begin
      v[XLEN-1:16] = '1;
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] store_into(logic [XLEN-1:0] word, lsu_op_e op,
                                                 int off, logic [XLEN-1:0] data);
    logic [XLEN-1:0] w;
    w = word;
    for (int i = 0; i < size_of(op); i++) begin
      w[8*(off+i) +: 8] = data[8*i +: 8];
    end
    return w;
  endfunction

  function automatic logic [XLEN-1:0] merge_bytes(logic [XLEN-1:0] old,
                                                  logic [XLEN-1:0] data,
                                                  logic [BE_W-1:0] be);
    logic [XLEN-1:0] w;
    w = old;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        w[8*i +: 8] = data[8*i +: 8];
      end
    end
    return w;
  endfunction

  function automatic string fmt_result(lsu_result_t r);
    return $sformatf("v=%0b id=%0d data=%h ex=%0b cause=%0d tval=%h",
                     r.valid, r.trans_id, r.result, r.ex.valid, r.ex.cause, r.ex.tval);
  endfunction

  // ------------------------------------------------------------------
  // Memory model and result monitor
  // ------------------------------------------------------------------
  // Grant follows req within the cycle, gated by a random stall
  always_comb begin
    ld_mem_rsp        = '0;
    ld_mem_rsp.gnt    = ld_mem_req.req && ld_grant_ok;
    ld_mem_rsp.rvalid = ld_rvalid;
    ld_mem_rsp.rdata  = ld_rdata;
    st_mem_rsp        = '0;
    st_mem_rsp.gnt    = st_mem_req.req && st_grant_ok;
  end

  always @(negedge clk) begin : mem_model
    logic     ld_fire;
    logic     st_fire;
    mem_req_t ld_req;
    mem_req_t st_req;
    ld_fire = ld_mem_req.req && ld_mem_rsp.gnt;
    st_fire = st_mem_req.req && st_mem_rsp.gnt && st_mem_req.we;
    ld_req  = ld_mem_req;
    st_req  = st_mem_req;
    @(posedge clk);
    #1;
    if (st_fire) begin
      mem[word_index(st_req.addr)] = merge_bytes(mem[word_index(st_req.addr)],
                                                 st_req.wdata, st_req.be);
    end
    ld_rvalid   = ld_fire;
    ld_rdata    = ld_fire ? mem[word_index(ld_req.addr)] : '0;
    ld_grant_ok = ($random(seed) & 3) != 0;
    st_grant_ok = ($random(seed) & 3) != 0;
  end

  always @(negedge clk) begin : result_monitor
    expect_t obs;
    if (ld_mem_req.req || st_mem_req.req) begin
      req_cycles++;
    end
    if (load_result.valid) begin
      obs     = '0;
      obs.res = load_result;
      obs_q.push_back(obs);
    end
    if (store_result.valid) begin
      obs          = '0;
      obs.is_store = 1'b1;
      obs.res      = store_result;
      obs_q.push_back(obs);
    end
  end

  // ------------------------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------------------------
  task automatic report_error(string msg);
    $display("CHECK FAILED @ %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic note_failure(string msg);
    $display("ERROR @ %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_load_result(lsu_result_t got, lsu_result_t exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("load got %s, expected %s", fmt_result(got), fmt_result(exp)));
    end
  endtask

  task automatic check_store_result(lsu_result_t got, lsu_result_t exp, int idx);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("store got %s, expected %s", fmt_result(got), fmt_result(exp)));
    end
    if (mem[idx] !== ref_mem[idx]) begin
      report_error($sformatf("memory word %0d is %h, expected %h", idx, mem[idx], ref_mem[idx]));
    end
  endtask

  task automatic finish_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("[%0t ns] test %s passed", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t ns] test %s failed with %0d error(s)", $time, name,
               errors - errors_before);
    end
  endtask

  // ------------------------------------------------------------------
  // Issue and result collection
  // ------------------------------------------------------------------
  // Records the expected result, then waits for a free entry and issues
  task automatic issue(lsu_op_e op, logic [XLEN-1:0] a, int imm, logic [XLEN-1:0] b,
                       int tid);
    expect_t           e;
    logic [IMM_W-1:0]  imm_bits;
    logic [ADDR_W-1:0] addr;
    int                idx;
    int                off;
    imm_bits = IMM_W'(imm);
    addr     = a + ADDR_W'($signed(imm_bits));
    idx      = word_index(addr);
    off      = int'(addr[1:0]);
    e              = '0;
    e.is_store     = op inside {SB, SH, SW};
    e.word_idx     = addr[9:2];
    e.res.valid    = 1'b1;
    e.res.trans_id = TRANS_ID_W'(tid);
    if (is_misaligned(op, addr)) begin
      e.res.ex.valid = 1'b1;
      e.res.ex.cause = e.is_store ? XLEN'(6) : XLEN'(4);
      e.res.ex.tval  = addr;
    end else if (e.is_store) begin
      ref_mem[idx] = store_into(ref_mem[idx], op, off, b);
    end else begin
      e.res.result = load_value(op, ref_mem[idx], off);
    end
    exp_q.push_back(e);
    while (!lsu_ready) begin
      @(posedge clk);
      #1;
    end
    fu_data.op        = op;
    fu_data.operand_a = a;
    fu_data.imm       = imm_bits;
    fu_data.operand_b = b;
    fu_data.trans_id  = TRANS_ID_W'(tid);
    lsu_valid         = 1'b1;
    @(posedge clk);
    #1;
    lsu_valid = 1'b0;
  endtask

  task automatic drain_results();
    expect_t e;
    expect_t o;
    int      waited;
    waited = 0;
    while (obs_q.size() < exp_q.size() && waited < WAIT_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (obs_q.size() < exp_q.size()) begin
      note_failure($sformatf("%0d result(s) did not arrive within %0d cycles",
                             exp_q.size() - obs_q.size(), WAIT_CYCLES));
    end
    while (exp_q.size() > 0 && obs_q.size() > 0) begin
      e = exp_q.pop_front();
      o = obs_q.pop_front();
      if (o.is_store != e.is_store) begin
        note_failure($sformatf("result for id %0d came back on the wrong port",
                               e.res.trans_id));
      end else if (e.is_store) begin
        check_store_result(o.res, e.res, int'(e.word_idx));
      end else begin
        check_load_result(o.res, e.res);
      end
    end
    if (obs_q.size() > 0) begin
      note_failure($sformatf("%0d unexpected result(s) came back", obs_q.size()));
    end
    exp_q.delete();
    obs_q.delete();
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic reset_state();
    int e0;
    e0    = errors;
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    checks++;
    if (lsu_ready !== 1'b1) begin
      report_error("lsu_ready_o is not high after reset");
    end
    if (ld_mem_req.req !== 1'b0 || st_mem_req.req !== 1'b0) begin
      report_error("a memory req bit is set after reset");
    end
    if (load_result.valid !== 1'b0 || store_result.valid !== 1'b0) begin
      report_error("a result valid bit is set after reset");
    end
    obs_q.delete();
    finish_test("reset_state", e0);
  endtask

  task automatic word_store_then_load();
    int              e0;
    logic [XLEN-1:0] data;
    e0   = errors;
    data = $random(seed);
    issue(SW, 32'h30, 16, data, 1);
    // Same address reached with a negative immediate
    issue(LW, 32'h50, -16, '0, 2);
    drain_results();
    finish_test("word_store_load", e0);
  endtask

  task automatic subword_extension();
    int e0;
    e0 = errors;
    issue(SW, 32'h80, 0, 32'h8f7e_f00d, 0);
    for (int off = 0; off < 4; off++) begin
      issue(LB, 32'h80, off, '0, 2 * off + 1);
      issue(LBU, 32'h80, off, '0, 2 * off + 2);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue(LH, 32'h80, off, '0, off + 3);
      issue(LHU, 32'h80, off, '0, off + 4);
    end
    drain_results();
    finish_test("subword_ext", e0);
  endtask

  task automatic store_byte_lanes();
    int e0;
    e0 = errors;
    issue(SW, 32'hc0, 0, 32'h1122_3344, 0);
    issue(SB, 32'hc0, 1, 32'hffff_ffaa, 1);
    issue(SH, 32'hc4, -2, 32'h1234_beef, 2);
    issue(SB, 32'hc0, 3, 32'h0000_005a, 3);
    issue(LW, 32'hc0, 0, '0, 4);
    // Low half of the neighbouring word while its upper lanes survive
    issue(SH, 32'hc0, 4, 32'hffff_7777, 5);
    issue(LW, 32'hc0, 4, '0, 6);
    drain_results();
    finish_test("store_lanes", e0);
  endtask

  task automatic misaligned_access();
    int e0;
    int req_before;
    e0         = errors;
    req_before = req_cycles;
    issue(LH, 32'h100, 1, '0, 1);
    issue(SH, 32'h100, 3, 32'hdead_beef, 2);
    issue(LW, 32'h104, -2, '0, 3);
    issue(SW, 32'h108, 1, 32'hcafe_f00d, 4);
    issue(LHU, 32'h10c, 3, '0, 5);
    issue(SW, 32'h110, 2, 32'h0bad_0bad, 6);
    drain_results();
    checks++;
    if (req_cycles != req_before) begin
      report_error($sformatf("misaligned accesses raised req for %0d cycle(s)",
                             req_cycles - req_before));
    end
    finish_test("misaligned", e0);
  endtask

  task automatic mixed_burst();
    int                e0;
    int                off;
    int                k;
    lsu_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   data;
    e0 = errors;
    for (int n = 0; n < 24; n++) begin
      op   = lsu_op_e'(3'($random(seed)));
      addr = 32'h200 + ADDR_W'(($random(seed) & 7) * 4);
      off  = $random(seed) & 3;
      k    = $random(seed) & 255;
      data = $random(seed);
      if (size_of(op) == 2) begin
        off = off & 2;
      end else if (size_of(op) == 4) begin
        off = 0;
      end
      issue(op, addr + ADDR_W'(off - k), k, data, n);
    end
    drain_results();
    finish_test("burst_order", e0);
  endtask

  // ------------------------------------------------------------------
  // Test sequence and watchdog
  // ------------------------------------------------------------------
  initial begin
    rst_n        = 1'b0;
    lsu_valid    = 1'b0;
    fu_data      = '0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i * 4);
      ref_mem[i] = mem[i];
    end
    reset_state();
    word_store_then_load();
    subword_extension();
    store_byte_lanes();
    misaligned_access();
    mixed_burst();
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all tests completed", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- compile.f
common/lsu_cfg_pkg.sv
common/lsu_types_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_req_buffer.sv
load_unit/load_unit.sv
store_unit/store_unit.sv
hdl/lsu_result_pipe.sv
hdl/load_store_unit.sv
verif/lsu_props.sv
verif/tb_load_store_unit.sv

//--- Makefile
SIM      := verilator
TOP      := tb_load_store_unit
FILELIST := compile.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
